// ==== source/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int data_w = 32;
    localparam int bus_w = 16;
    localparam int addr_w = 32;
    localparam int reg_sel_w = 5;

    localparam logic [addr_w-1:0] reset_vector = 32'hffc0_0000; // base of boot rom
    localparam int bus_wait = 3;                        // cycles from address to data
    localparam int wait_w = $clog2(bus_wait + 1);

    typedef enum logic [3:0] {
        fetch1,
        eval1,
        fetch2,
        eval2,
        fetch3,
        eval3,
        store,
        load,
        load2,
        fault
    } state_e;

    typedef enum logic [2:0] {
        mode_inh    = 3'd0,
        mode_imm    = 3'd1,
        mode_regind = 3'd2,
        mode_reg    = 3'd3,
        mode_pcind  = 3'd5
    } mode_e;

    // bra is 0x20 in pcind mode, the same code as ldi in imm mode
    typedef enum logic [7:0] {
        op_nop  = 8'h00,
        op_mov  = 8'h10,
        op_cmp  = 8'h11,
        op_inc  = 8'h13,
        op_dec  = 8'h14,
        op_ldi  = 8'h20,
        op_beq  = 8'h21,
        op_bne  = 8'h22,
        op_bgtu = 8'h23,
        op_bgt  = 8'h24,
        op_bge  = 8'h25,
        op_ble  = 8'h26,
        op_blt  = 8'h27,
        op_bgeu = 8'h28,
        op_bltu = 8'h29,
        op_bleu = 8'h2a,
        op_brn  = 8'h2c,
        op_st   = 8'h30,
        op_ld   = 8'h31
    } opcode_e;

    typedef enum logic [3:0] {
        alu_and = 4'h0,
        alu_or  = 4'h1,
        alu_add = 4'h2,
        alu_sub = 4'h3,
        alu_xor = 4'h4
    } alu_op_e;

endpackage

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cpu_pkg::reg_sel_w-1:0] rd_sel1,
    input  logic [cpu_pkg::reg_sel_w-1:0] rd_sel2,
    input  logic [cpu_pkg::reg_sel_w-1:0] wr_sel,
    input  logic                          wr_en,
    input  logic [cpu_pkg::data_w-1:0]    wr_data,
    output logic [cpu_pkg::data_w-1:0]    rd_data1,
    output logic [cpu_pkg::data_w-1:0]    rd_data2
);

    logic [cpu_pkg::data_w-1:0] regs [2**cpu_pkg::reg_sel_w];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**cpu_pkg::reg_sel_w; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_sel] <= wr_data; // whole word only
        end
    end

    assign rd_data1 = regs[rd_sel1];
    assign rd_data2 = regs[rd_sel2];

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [cpu_pkg::data_w-1:0] a,
    input  logic [cpu_pkg::data_w-1:0] b,
    input  cpu_pkg::alu_op_e           alu_op,
    input  logic                       flags_load,
    output logic [cpu_pkg::data_w-1:0] result,
    output logic [3:0]                 ccr
);

    localparam int msb = cpu_pkg::data_w - 1;

    logic carry;
    logic overflow;

    always_comb begin
        carry    = 1'b0;
        overflow = 1'b0;
        case (alu_op)
            cpu_pkg::alu_and: result = a & b;
            cpu_pkg::alu_or:  result = a | b;
            cpu_pkg::alu_xor: result = a ^ b;
            cpu_pkg::alu_add: begin
                {carry, result} = {1'b0, a} + {1'b0, b};
                overflow = (a[msb] == b[msb]) && (result[msb] != a[msb]);
            end
            cpu_pkg::alu_sub: begin
                {carry, result} = {1'b0, a} - {1'b0, b}; // carry set on borrow
                overflow = (a[msb] != b[msb]) && (result[msb] != a[msb]);
            end
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ccr <= 4'h0;
        else if (flags_load)
            ccr <= {carry, result[msb], overflow, result == '0}; // c n v z
    end

endmodule

`default_nettype wire

// ==== source/bus_interface.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_interface (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [cpu_pkg::data_w-1:0] alu_result,
    input  logic [cpu_pkg::data_w-1:0] rd_data2,
    input  logic                       fetch_req,
    input  logic                       pc_advance,
    input  logic                       pc_branch,
    input  logic                       mar_load,
    input  logic                       mdr_load,
    input  logic                       store_req,
    output logic [cpu_pkg::addr_w-1:0] addrbus,
    output logic [cpu_pkg::bus_w-1:0]  data_out,
    output logic                       write_out,
    output logic [cpu_pkg::addr_w-1:0] branch_base
);

    logic [cpu_pkg::addr_w-1:0] pc;
    logic [cpu_pkg::addr_w-1:0] mar;
    logic [cpu_pkg::bus_w-1:0]  mdr;
    logic                       use_mar;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= cpu_pkg::reset_vector;
            use_mar   <= 1'b0;
            write_out <= 1'b0;
        end else begin
            if (pc_branch)
                pc <= alu_result; // pc plus offset
            else if (pc_advance)
                pc <= pc + 2;

            if (mar_load)
                use_mar <= 1'b1;
            else if (fetch_req)
                use_mar <= 1'b0;

            write_out <= store_req; // one cycle per request
        end
    end

    always_ff @(posedge clk) begin
        if (mar_load)
            mar <= alu_result;
        if (mdr_load)
            mdr <= rd_data2[cpu_pkg::bus_w-1:0];
    end

    assign addrbus     = use_mar ? mar : pc;
    assign data_out    = mdr;
    assign branch_base = pc;

endmodule

`default_nettype wire

// ==== source/cpu_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_control (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cpu_pkg::bus_w-1:0]     data_in,
    input  logic [3:0]                    ccr,
    input  logic [cpu_pkg::data_w-1:0]    alu_result,
    input  logic [cpu_pkg::data_w-1:0]    rd_data1,
    input  logic [cpu_pkg::data_w-1:0]    rd_data2,
    input  logic [cpu_pkg::addr_w-1:0]    branch_base,
    output logic [cpu_pkg::reg_sel_w-1:0] rd_sel1,
    output logic [cpu_pkg::reg_sel_w-1:0] rd_sel2,
    output logic [cpu_pkg::reg_sel_w-1:0] wr_sel,
    output logic                          wr_en,
    output logic [cpu_pkg::data_w-1:0]    wr_data,
    output logic [cpu_pkg::data_w-1:0]    alu_a,
    output logic [cpu_pkg::data_w-1:0]    alu_b,
    output cpu_pkg::alu_op_e              alu_op,
    output logic                          flags_load,
    output logic                          fetch_req,
    output logic                          pc_advance,
    output logic                          pc_branch,
    output logic                          mar_load,
    output logic                          mdr_load,
    output logic                          store_req
);

    cpu_pkg::state_e               state;
    cpu_pkg::state_e               state_next;
    logic [cpu_pkg::bus_w-1:0]     ir;
    logic [2*cpu_pkg::bus_w-1:0]   ext;      // words 2 and 3, shifted in
    logic [cpu_pkg::wait_w-1:0]    wait_cnt;
    cpu_pkg::mode_e                mode;
    logic [7:0]                    opcode;
    logic [cpu_pkg::reg_sel_w-1:0] ra;
    logic                          fetching;
    logic                          word_done;
    logic                          alu_func_ok;
    logic                          multi_word;
    logic                          taken;
    logic                          c;
    logic                          n;
    logic                          v;
    logic                          z;
    logic [cpu_pkg::data_w-1:0]    imm16;
    logic [cpu_pkg::data_w-1:0]    off11;

    assign mode   = cpu_pkg::mode_e'(ir[15:13]);
    assign opcode = ir[12:5];
    assign ra     = ir[4:0];
    assign {c, n, v, z} = ccr;

    assign imm16 = {{(cpu_pkg::data_w - cpu_pkg::bus_w){ext[15]}}, ext[15:0]};
    assign off11 = {{(cpu_pkg::data_w - 11){ext[10]}}, ext[10:0]};

    assign fetching = state inside {cpu_pkg::fetch1, cpu_pkg::fetch2, cpu_pkg::fetch3};
    assign fetch_req  = fetching && (wait_cnt == 0);
    assign word_done  = fetching && (wait_cnt == 1); // last wait cycle, data valid
    assign pc_advance = word_done;

    assign alu_func_ok = opcode[3:0] <= cpu_pkg::alu_xor;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= cpu_pkg::fetch1;
            wait_cnt <= '0;
        end else begin
            state <= state_next;
            if (fetch_req)
                wait_cnt <= cpu_pkg::bus_wait[cpu_pkg::wait_w-1:0];
            else if (fetching)
                wait_cnt <= wait_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (word_done && state == cpu_pkg::fetch1)
            ir <= data_in;
        if (word_done && state != cpu_pkg::fetch1)
            ext <= {ext[cpu_pkg::bus_w-1:0], data_in};
    end

    // instructions that need a second word
    always_comb begin
        case (mode)
            cpu_pkg::mode_reg:
                multi_word = (opcode[7:4] == 4'h0 && alu_func_ok)
                             || opcode == cpu_pkg::op_mov || opcode == cpu_pkg::op_cmp;
            cpu_pkg::mode_imm:
                multi_word = (opcode[7:4] == 4'h1 && alu_func_ok) || opcode == cpu_pkg::op_ldi;
            cpu_pkg::mode_regind:
                multi_word = opcode == cpu_pkg::op_st || opcode == cpu_pkg::op_ld;
            cpu_pkg::mode_pcind:
                multi_word = opcode[7:4] == 4'h2 && opcode <= cpu_pkg::op_brn
                             && opcode != 8'h2b;
            default:
                multi_word = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            cpu_pkg::op_beq:  taken = z;
            cpu_pkg::op_bne:  taken = !z;
            cpu_pkg::op_bgtu: taken = !(z || c);
            cpu_pkg::op_bgt:  taken = !(z || (n ^ v));
            cpu_pkg::op_bge:  taken = !(n ^ v);
            cpu_pkg::op_ble:  taken = z || (n ^ v);
            cpu_pkg::op_blt:  taken = n ^ v;
            cpu_pkg::op_bgeu: taken = !c;
            cpu_pkg::op_bltu: taken = c;          // carry is borrow after cmp
            cpu_pkg::op_bleu: taken = c || z;
            cpu_pkg::op_brn:  taken = 1'b0;
            default:          taken = 1'b1;       // bra
        endcase
    end

    always_comb begin
        state_next = state;
        rd_sel1    = '0;
        rd_sel2    = '0;
        wr_sel     = ra;
        wr_en      = 1'b0;
        wr_data    = alu_result;
        alu_a      = rd_data1;
        alu_b      = rd_data2;
        alu_op     = cpu_pkg::alu_add;
        flags_load = 1'b0;
        pc_branch  = 1'b0;
        mar_load   = 1'b0;
        mdr_load   = 1'b0;
        store_req  = 1'b0;
        case (state)
            cpu_pkg::fetch1: if (word_done) state_next = cpu_pkg::eval1;
            cpu_pkg::fetch2: if (word_done) state_next = cpu_pkg::eval2;
            cpu_pkg::fetch3: if (word_done) state_next = cpu_pkg::eval3;
            cpu_pkg::eval1: begin
                if (mode == cpu_pkg::mode_inh && opcode == cpu_pkg::op_nop) begin
                    state_next = cpu_pkg::fetch1;
                end else if (mode == cpu_pkg::mode_reg
                             && (opcode == cpu_pkg::op_inc || opcode == cpu_pkg::op_dec)) begin
                    rd_sel1    = ra;
                    alu_b      = 1;
                    alu_op     = (opcode == cpu_pkg::op_inc) ? cpu_pkg::alu_add : cpu_pkg::alu_sub;
                    wr_en      = 1'b1;
                    state_next = cpu_pkg::fetch1;
                end else if (multi_word) begin
                    state_next = cpu_pkg::fetch2;
                end else begin
                    state_next = cpu_pkg::fault;
                end
            end
            cpu_pkg::eval2: begin
                state_next = cpu_pkg::fetch1;
                case (mode)
                    cpu_pkg::mode_reg: begin
                        rd_sel1 = ext[12:8];
                        rd_sel2 = ext[4:0];
                        if (opcode == cpu_pkg::op_mov) begin
                            wr_data = rd_data1;
                            wr_en   = 1'b1;
                        end else if (opcode == cpu_pkg::op_cmp) begin
                            rd_sel1    = ra;
                            rd_sel2    = ext[12:8];
                            alu_op     = cpu_pkg::alu_sub;
                            flags_load = 1'b1;
                        end else begin
                            alu_op = cpu_pkg::alu_op_e'(opcode[3:0]);
                            wr_en  = 1'b1;
                        end
                    end
                    cpu_pkg::mode_imm: begin
                        if (opcode == cpu_pkg::op_ldi) begin
                            state_next = cpu_pkg::fetch3;
                        end else begin
                            rd_sel1 = ra;
                            alu_b   = imm16;
                            alu_op  = cpu_pkg::alu_op_e'(opcode[3:0]);
                            wr_en   = 1'b1;
                        end
                    end
                    cpu_pkg::mode_regind: begin
                        rd_sel1  = ext[15:11]; // base register
                        rd_sel2  = ra;
                        alu_b    = off11;
                        mar_load = 1'b1;
                        if (opcode == cpu_pkg::op_st) begin
                            mdr_load   = 1'b1;
                            state_next = cpu_pkg::store;
                        end else begin
                            state_next = cpu_pkg::load;
                        end
                    end
                    default: begin
                        alu_a     = branch_base; // pc already past word 2
                        alu_b     = imm16;
                        pc_branch = taken;
                    end
                endcase
            end
            cpu_pkg::eval3: begin
                wr_data    = ext;
                wr_en      = 1'b1;
                state_next = cpu_pkg::fetch1;
            end
            cpu_pkg::store: begin
                store_req  = 1'b1;
                state_next = cpu_pkg::fetch1;
            end
            cpu_pkg::load: state_next = cpu_pkg::load2;
            cpu_pkg::load2: begin
                wr_data    = {{(cpu_pkg::data_w - cpu_pkg::bus_w){1'b0}}, data_in};
                wr_en      = 1'b1;
                state_next = cpu_pkg::fetch1;
            end
            default: state_next = cpu_pkg::fault; // parked, no bus cycles
        endcase
    end

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic [cpu_pkg::addr_w-1:0]  addrbus,
    input  logic [cpu_pkg::bus_w-1:0]   data_in,
    output logic [cpu_pkg::bus_w-1:0]   data_out,
    output logic                        write_out,
    output logic [3:0]                  ccr
);

    logic [cpu_pkg::reg_sel_w-1:0] rd_sel1;
    logic [cpu_pkg::reg_sel_w-1:0] rd_sel2;
    logic [cpu_pkg::reg_sel_w-1:0] wr_sel;
    logic                          wr_en;
    logic [cpu_pkg::data_w-1:0]    wr_data;
    logic [cpu_pkg::data_w-1:0]    rd_data1;
    logic [cpu_pkg::data_w-1:0]    rd_data2;
    logic [cpu_pkg::data_w-1:0]    alu_a;
    logic [cpu_pkg::data_w-1:0]    alu_b;
    logic [cpu_pkg::data_w-1:0]    alu_result;
    cpu_pkg::alu_op_e              alu_op;
    logic                          flags_load;
    logic                          fetch_req;
    logic                          pc_advance;
    logic                          pc_branch;
    logic                          mar_load;
    logic                          mdr_load;
    logic                          store_req;
    logic [cpu_pkg::addr_w-1:0]    branch_base;

    cpu_control control_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_in     (data_in),
        .ccr         (ccr),
        .alu_result  (alu_result),
        .rd_data1    (rd_data1),
        .rd_data2    (rd_data2),
        .branch_base (branch_base),
        .rd_sel1     (rd_sel1),
        .rd_sel2     (rd_sel2),
        .wr_sel      (wr_sel),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_op      (alu_op),
        .flags_load  (flags_load),
        .fetch_req   (fetch_req),
        .pc_advance  (pc_advance),
        .pc_branch   (pc_branch),
        .mar_load    (mar_load),
        .mdr_load    (mdr_load),
        .store_req   (store_req)
    );

    register_file register_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_sel1  (rd_sel1),
        .rd_sel2  (rd_sel2),
        .wr_sel   (wr_sel),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    alu alu_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .a          (alu_a),
        .b          (alu_b),
        .alu_op     (alu_op),
        .flags_load (flags_load),
        .result     (alu_result),
        .ccr        (ccr)
    );

    bus_interface bus_interface_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .alu_result  (alu_result),
        .rd_data2    (rd_data2),
        .fetch_req   (fetch_req),
        .pc_advance  (pc_advance),
        .pc_branch   (pc_branch),
        .mar_load    (mar_load),
        .mdr_load    (mdr_load),
        .store_req   (store_req),
        .addrbus     (addrbus),
        .data_out    (data_out),
        .write_out   (write_out),
        .branch_base (branch_base)
    );

endmodule

`default_nettype wire

// ==== sim/cpu_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_asserts (
    input logic                       clk,
    input logic                       rst_n,
    input logic [cpu_pkg::addr_w-1:0] addrbus,
    input logic                       write_out,
    input logic                       fetch_req
);

    int failures = 0;

    write_single: assert property (@(posedge clk) disable iff (!rst_n)
        write_out |=> !write_out)
        else begin
            $error("write_out held high for two cycles");
            failures++;
        end

    // address settles one cycle after the request, then holds until data is sampled
    read_stable: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req |-> ##2 $stable(addrbus) ##1 $stable(addrbus))
        else begin
            $error("addrbus moved during a read wait");
            failures++;
        end

    reset_quiet: assert property (@(posedge clk) !rst_n |=> !write_out)
        else begin
            $error("write_out not cleared by reset");
            failures++;
        end

endmodule

bind cpu_top cpu_asserts cpu_asserts_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .addrbus   (addrbus),
    .write_out (write_out),
    .fetch_req (fetch_req)
);

`default_nettype wire

// ==== sim/tb_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
    input logic                       clk,
    input logic                       rst_n,
    input logic [cpu_pkg::addr_w-1:0] addrbus,
    input logic [cpu_pkg::bus_w-1:0]  data_out,
    input logic                       write_out,
    input logic [3:0]                 ccr
);

    int   errors = 0;
    int   total_stores = 0;
    int   store_idx = 0;
    int   errors_before = 0;
    logic first_cycle = 1'b1;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            first_cycle = 1'b1;
        end else begin
            if (first_cycle && addrbus !== cpu_pkg::reset_vector)
                report_mismatch("addrbus", cpu_pkg::reset_vector, addrbus);
            if (first_cycle && write_out !== 1'b0)
                report_mismatch("write_out", 32'd0, {31'd0, write_out});
            first_cycle = 1'b0;
            if (write_out === 1'b1) begin
                if (store_idx >= tb_top.exp_count) begin
                    $display("extra store at %0t ns to %h, only %0d stores expected",
                             $time, addrbus, tb_top.exp_count);
                    errors++;
                end else begin
                    if (addrbus !== tb_top.exp_addr[store_idx])
                        report_mismatch("addrbus", tb_top.exp_addr[store_idx], addrbus);
                    if (data_out !== tb_top.exp_data[store_idx])
                        report_mismatch("data_out", {16'd0, tb_top.exp_data[store_idx]},
                                        {16'd0, data_out});
                    if (ccr !== tb_top.exp_ccr[store_idx])
                        report_mismatch("ccr", {28'd0, tb_top.exp_ccr[store_idx]}, {28'd0, ccr});
                end
                store_idx++;
            end
        end
    end

    // called once the core is parked in fault
    task automatic end_of_test(input int test_num);
        if (store_idx < tb_top.exp_count) begin
            $display("test %0d: only %0d of %0d expected stores appeared on the bus",
                     test_num, store_idx, tb_top.exp_count);
            errors++;
        end
        for (int r = 0; r < 32; r++) begin
            if (tb_top.cpu_top_i.register_file_i.regs[r] !== tb_top.exp_regs[r])
                report_mismatch($sformatf("regs[%0d]", r), tb_top.exp_regs[r],
                                tb_top.cpu_top_i.register_file_i.regs[r]);
        end
        $display("test %0d: %0d stores, %0d mismatches", test_num, store_idx,
                 errors - errors_before);
        total_stores += store_idx;
        store_idx = 0;
        errors_before = errors;
    endtask

endmodule

`default_nettype wire

// ==== sim/tb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_top;

    localparam int n_tests = 8;
    localparam int n_instr = 30;
    localparam int max_words = 8 * 3 + n_instr * 5 + 1; // ldi prelude, worst case body, end word
    localparam int period = 10;
    localparam logic [31:0] data_base = 32'h0000_1400;

    logic                       clk;
    logic                       rst_n;
    logic [cpu_pkg::addr_w-1:0] addrbus;
    logic [cpu_pkg::bus_w-1:0]  data_in;
    logic [cpu_pkg::bus_w-1:0]  data_out;
    logic                       write_out;
    logic [3:0]                 ccr;

    logic [15:0] mem [4096];
    logic [15:0] model_mem [4096];
    logic [31:0] exp_regs [32];
    logic [31:0] exp_addr [256];
    logic [15:0] exp_data [256];
    logic [3:0]  exp_ccr [256];
    int          exp_count;
    logic [31:0] end_addr;
    int          seed = 56;
    int          wp;
    logic [10:0] last_off;

    initial clk = 1'b0;
    always #(period / 2) clk = ~clk;

    assign data_in = mem[addrbus[12:1]]; // upper address bits alias
    always @(posedge clk) begin
        if (rst_n && write_out)
            mem[addrbus[12:1]] <= data_out;
    end

    cpu_top cpu_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .addrbus   (addrbus),
        .data_in   (data_in),
        .data_out  (data_out),
        .write_out (write_out),
        .ccr       (ccr)
    );

    tb_checker checker_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .addrbus   (addrbus),
        .data_out  (data_out),
        .write_out (write_out),
        .ccr       (ccr)
    );

    task automatic put_word(input logic [15:0] w);
        mem[wp] = w;
        wp++;
    endtask

    task automatic emit_store(input logic [4:0] ra);
        last_off = 11'({$random(seed)}) & 11'h7fe; // even, signed around data_base
        put_word({3'd2, 8'h30, ra});
        put_word({5'd8, last_off});
    endtask

    task automatic build_program;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rc;
        logic [3:0]  f;
        logic [7:0]  op;
        logic [10:0] off;
        logic [31:0] value;
        int          kind;
        for (int i = 0; i < 4096; i++)
            mem[i] = 16'(i * 40503) ^ 16'h5a3c;
        wp = 0;
        last_off = '0;
        for (int r = 1; r <= 8; r++) begin
            value = (r == 8) ? data_base : $random(seed); // r8 is the load/store base
            put_word({3'd1, 8'h20, 5'(r)});
            put_word(value[31:16]);
            put_word(value[15:0]);
        end
        for (int k = 0; k < n_instr; k++) begin
            kind = {$random(seed)} % 9;
            ra = 5'(1 + {$random(seed)} % 7);
            rb = 5'(1 + {$random(seed)} % 8);
            rc = 5'(1 + {$random(seed)} % 8);
            f = 4'({$random(seed)} % 5);
            case (kind)
                0: begin
                    put_word({3'd3, 4'h0, f, ra});
                    put_word({3'd0, rb, 3'd0, rc});
                end
                1: begin
                    put_word({3'd1, 4'h1, f, ra});
                    put_word(16'($random(seed)));
                end
                2: begin
                    value = $random(seed);
                    put_word({3'd1, 8'h20, ra});
                    put_word(value[31:16]);
                    put_word(value[15:0]);
                end
                3: begin
                    put_word({3'd3, 8'h10, ra});
                    put_word({3'd0, rb, 8'd0});
                end
                4: begin
                    put_word({3'd3, 8'h11, ra});
                    put_word({3'd0, rb, 8'd0});
                end
                5: put_word({3'd3, f[0] ? 8'h13 : 8'h14, ra});
                6: begin
                    off = f[0] ? last_off : (11'({$random(seed)}) & 11'h7fe); // often reread
                    put_word({3'd2, 8'h31, ra});
                    put_word({5'd8, off});
                end
                7: emit_store(rb);
                default: begin
                    f = 4'({$random(seed)} % 12);
                    op = (f == 4'd11) ? 8'h2c : 8'h20 + 8'(f);
                    put_word({3'd5, op, 5'd0});
                    put_word(16'd4); // skip the store that follows
                    emit_store(rb);
                end
            endcase
            if (kind != 4 && kind < 7)
                emit_store(ra);
        end
        put_word(({$random(seed)} % 2) ? 16'hffff : {3'd3, 8'h0f, 5'd0}); // illegal
    endtask

    function automatic logic [31:0] model_alu(input logic [3:0] f, input logic [31:0] a,
                                              input logic [31:0] b);
        case (f)
            4'h0: return a & b;
            4'h1: return a | b;
            4'h2: return a + b;
            4'h3: return a - b;
            default: return a ^ b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [7:0] op, input logic [3:0] cc);
        logic c;
        logic n;
        logic v;
        logic z;
        {c, n, v, z} = cc;
        case (op)
            8'h20: return 1'b1;
            8'h21: return z;
            8'h22: return !z;
            8'h23: return !c && !z;
            8'h24: return !z && (n == v);
            8'h25: return n == v;
            8'h26: return z || (n != v);
            8'h27: return n != v;
            8'h28: return !c;
            8'h29: return c;
            8'h2a: return c || z;
            default: return 1'b0;
        endcase
    endfunction

    task automatic run_model;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] diff;
        logic [31:0] addr;
        logic [15:0] w1;
        logic [15:0] w2;
        logic [2:0]  mode;
        logic [7:0]  op;
        logic [4:0]  ra;
        logic [3:0]  cc;
        logic        two_words;
        int          steps;
        for (int i = 0; i < 4096; i++)
            model_mem[i] = mem[i];
        for (int r = 0; r < 32; r++)
            exp_regs[r] = '0;
        pc = cpu_pkg::reset_vector;
        cc = 4'h0;
        exp_count = 0;
        steps = 0;
        while (steps < 4 * max_words) begin
            steps++;
            w1 = model_mem[pc[12:1]];
            pc = pc + 2;
            mode = w1[15:13];
            op = w1[12:5];
            ra = w1[4:0];
            w2 = model_mem[pc[12:1]];
            two_words = (mode == 3'd3 && (op <= 8'h04 || op == 8'h10 || op == 8'h11))
                || (mode == 3'd1 && ((op >= 8'h10 && op <= 8'h14) || op == 8'h20))
                || (mode == 3'd2 && (op == 8'h30 || op == 8'h31))
                || (mode == 3'd5 && ((op >= 8'h20 && op <= 8'h2a) || op == 8'h2c));
            if (mode == 3'd0 && op == 8'h00) begin
                steps = steps; // nop
            end else if (mode == 3'd3 && op == 8'h13) begin
                exp_regs[ra] = exp_regs[ra] + 1;
            end else if (mode == 3'd3 && op == 8'h14) begin
                exp_regs[ra] = exp_regs[ra] - 1;
            end else if (!two_words) begin
                break; // fault
            end else begin
                pc = pc + 2;
                a = exp_regs[w2[12:8]];
                case (mode)
                    3'd3: begin
                        if (op == 8'h10) begin
                            exp_regs[ra] = a;
                        end else if (op == 8'h11) begin
                            diff = exp_regs[ra] - a; // rA minus rB
                            cc[3] = exp_regs[ra] < a;
                            cc[2] = diff[31];
                            cc[1] = (exp_regs[ra][31] != a[31]) && (diff[31] != exp_regs[ra][31]);
                            cc[0] = diff == 32'h0;
                        end else begin
                            exp_regs[ra] = model_alu(op[3:0], a, exp_regs[w2[4:0]]);
                        end
                    end
                    3'd1: begin
                        if (op == 8'h20) begin
                            exp_regs[ra] = {w2, model_mem[pc[12:1]]};
                            pc = pc + 2;
                        end else begin
                            exp_regs[ra] = model_alu(op[3:0], exp_regs[ra], {{16{w2[15]}}, w2});
                        end
                    end
                    3'd2: begin
                        addr = exp_regs[w2[15:11]] + {{21{w2[10]}}, w2[10:0]};
                        if (op == 8'h30) begin
                            exp_addr[exp_count] = addr;
                            exp_data[exp_count] = exp_regs[ra][15:0];
                            exp_ccr[exp_count] = cc;
                            exp_count++;
                            model_mem[addr[12:1]] = exp_regs[ra][15:0];
                        end else begin
                            exp_regs[ra] = {16'h0, model_mem[addr[12:1]]};
                        end
                    end
                    default: begin
                        if (branch_taken(op, cc))
                            pc = pc + {{16{w2[15]}}, w2};
                    end
                endcase
            end
        end
        end_addr = pc; // pc past the illegal word
    endtask

    initial begin
        int total_errors;
        rst_n = 1'b0;
        for (int t = 0; t < n_tests; t++) begin
            if (t > 0) begin
                @(posedge clk);
                #1 rst_n = 1'b0;
            end
            build_program();
            run_model();
            repeat (8) @(posedge clk);
            #1 rst_n = 1'b1;
            while (addrbus !== end_addr)
                @(negedge clk);
            repeat (10) @(negedge clk); // no bus writes once parked
            checker_i.end_of_test(t);
        end
        total_errors = checker_i.errors + cpu_top_i.cpu_asserts_i.failures;
        $display("%0d tests, %0d stores checked, %0d errors", n_tests,
                 checker_i.total_stores, total_errors);
        if (total_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial begin
        #(n_tests * (max_words * 20 + 20) * period);
        $display("timeout: the core did not reach the end of its program");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
source/cpu_pkg.sv
source/register_file.sv
source/alu.sv
source/bus_interface.sv
source/cpu_control.sv
source/cpu_top.sv
sim/cpu_asserts.sv
sim/tb_checker.sv
sim/tb_top.sv
